// ==== logic/tpu_pkg.sv ====
`default_nettype none

package tpu_pkg;

    // operand widths
    localparam int ACT_W = 8;
    localparam int W_W   = 8;

    // wide enough for four full 16-bit products, larger arrays wrap
    localparam int RES_W = 20;

    // activation element, unsigned
    typedef logic [ACT_W-1:0] act_t;

    // weight element, unsigned
    typedef logic [W_W-1:0] wgt_t;

    // accumulated result, wraps modulo 2^RES_W
    typedef logic [RES_W-1:0] res_t;

endpackage

`default_nettype wire

// ==== logic/mac_cell.sv ====
`timescale 1ns/1ps
`default_nettype none

module mac_cell (
    input  logic          clk_i,
    input  logic          rst_i,
    input  logic          hold_i,
    input  logic          load_i,
    input  logic          sel_i,
    input  tpu_pkg::wgt_t wgt_i,
    input  tpu_pkg::act_t act_i,
    input  tpu_pkg::res_t psum_i,
    output tpu_pkg::res_t psum_o,
    output tpu_pkg::act_t act_o,
    output tpu_pkg::wgt_t wgt_o
);

    // two weight banks, sel_i picks the active one
    tpu_pkg::wgt_t bank_q [2];
    tpu_pkg::act_t act_q;
    tpu_pkg::res_t psum_q;
    tpu_pkg::wgt_t wgt_active;
    tpu_pkg::res_t product;

    assign wgt_active = bank_q[sel_i];

    // zero-extend before multiplying so the product is kept whole
    assign product = tpu_pkg::res_t'(act_i) * tpu_pkg::res_t'(wgt_active);

    // shadow bank goes up to the row above
    assign wgt_o  = bank_q[!sel_i];
    assign act_o  = act_q;
    assign psum_o = psum_q;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            bank_q[0] <= '0;
            bank_q[1] <= '0;
            act_q     <= '0;
            psum_q    <= '0;
        end else if (!hold_i) begin
            if (load_i) begin
                bank_q[!sel_i] <= wgt_i;
            end
            act_q  <= act_i;
            // truncates to RES_W
            psum_q <= product + psum_i;
        end
    end

endmodule

`default_nettype wire

// ==== logic/skew_line.sv ====
`timescale 1ns/1ps
`default_nettype none

module skew_line #(
    parameter int  ARRAY_N = 4,
    parameter type data_t  = logic [7:0],
    // 0: lane k delays k cycles, 1: lane k delays ARRAY_N-1-k cycles
    parameter bit  DESCEND = 1'b0
) (
    input  logic  clk_i,
    input  logic  rst_i,
    input  logic  hold_i,
    input  data_t lane_i [ARRAY_N],
    output data_t lane_o [ARRAY_N]
);

    for (genvar k = 0; k < ARRAY_N; k++) begin : g_lane
        localparam int DEPTH = DESCEND ? ARRAY_N - 1 - k : k;

        if (DEPTH == 0) begin : g_pass
            assign lane_o[k] = lane_i[k];
        end else begin : g_delay
            data_t stage_q [DEPTH];

            always_ff @(posedge clk_i) begin
                if (rst_i) begin
                    for (int i = 0; i < DEPTH; i++) begin
                        stage_q[i] <= '0;
                    end
                end else if (!hold_i) begin
                    stage_q[0] <= lane_i[k];
                    for (int i = 1; i < DEPTH; i++) begin
                        stage_q[i] <= stage_q[i-1];
                    end
                end
            end

            assign lane_o[k] = stage_q[DEPTH-1];
        end
    end

endmodule

`default_nettype wire

// ==== logic/mac_array.sv ====
`timescale 1ns/1ps
`default_nettype none

module mac_array #(
    parameter int ARRAY_N = 4
) (
    input  logic          clk_i,
    input  logic          rst_i,
    input  logic          hold_i,
    input  logic          load_i,
    input  logic          sel_i,
    input  tpu_pkg::wgt_t wgt_row_i [ARRAY_N],
    input  tpu_pkg::act_t act_i     [ARRAY_N],
    output tpu_pkg::res_t row_res_o [ARRAY_N]
);

    // wgt_link[r] feeds row r from below, entry ARRAY_N is the bottom edge
    tpu_pkg::wgt_t wgt_link  [ARRAY_N+1][ARRAY_N];
    // act_link[r] feeds row r from above
    tpu_pkg::act_t act_link  [ARRAY_N+1][ARRAY_N];
    // psum_link[r][c] enters column c of row r
    tpu_pkg::res_t psum_link [ARRAY_N][ARRAY_N+1];

    for (genvar c = 0; c < ARRAY_N; c++) begin : g_edge_col
        assign wgt_link[ARRAY_N][c] = wgt_row_i[c];
        assign act_link[0][c]       = act_i[c];
    end

    for (genvar r = 0; r < ARRAY_N; r++) begin : g_edge_row
        // each row starts its sum from zero
        assign psum_link[r][0] = '0;
        assign row_res_o[r]    = psum_link[r][ARRAY_N];
    end

    for (genvar r = 0; r < ARRAY_N; r++) begin : g_row
        for (genvar c = 0; c < ARRAY_N; c++) begin : g_col
            mac_cell u_cell (
                .clk_i  (clk_i),
                .rst_i  (rst_i),
                .hold_i (hold_i),
                .load_i (load_i),
                .sel_i  (sel_i),
                .wgt_i  (wgt_link[r+1][c]),
                .act_i  (act_link[r][c]),
                .psum_i (psum_link[r][c]),
                .psum_o (psum_link[r][c+1]),
                .act_o  (act_link[r+1][c]),
                .wgt_o  (wgt_link[r][c])
            );
        end
    end

endmodule

`default_nettype wire

// ==== logic/tpu_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module tpu_ctrl #(
    parameter int ARRAY_N = 4
) (
    input  logic clk_i,
    input  logic rst_i,
    input  logic stall_i,
    input  logic wgt_valid_i,
    input  logic wgt_commit_i,
    input  logic in_valid_i,
    output logic load_o,
    output logic sel_o,
    output logic hold_o,
    output logic wgt_loaded_o,
    output logic busy_o,
    output logic out_valid_o
);

    // skew + array + deskew latency
    localparam int DEPTH = 2 * ARRAY_N - 1;
    localparam int CNT_W = $clog2(ARRAY_N + 1);

    logic [CNT_W-1:0] row_cnt_q;
    logic             sel_q;
    logic [DEPTH-1:0] vld_q;
    logic             commit_ok;

    // shadow bank full once every row is in
    assign wgt_loaded_o = (row_cnt_q == CNT_W'(ARRAY_N));

    // rows past a full shadow bank are dropped
    assign load_o = wgt_valid_i && !stall_i && !wgt_loaded_o;

    // swap only with an empty pipeline and nothing entering it
    assign commit_ok = wgt_commit_i && !stall_i && wgt_loaded_o
                       && !busy_o && !in_valid_i;

    assign busy_o      = |vld_q;
    assign out_valid_o = vld_q[DEPTH-1];
    assign sel_o       = sel_q;

    // the whole datapath freezes with the valid pipe
    assign hold_o = stall_i;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            row_cnt_q <= '0;
            sel_q     <= 1'b0;
            vld_q     <= '0;
        end else if (!stall_i) begin
            // one bit per vector in flight
            vld_q <= {vld_q[DEPTH-2:0], in_valid_i};

            if (commit_ok) begin
                sel_q     <= !sel_q;
                row_cnt_q <= '0;
            end else if (load_o) begin
                row_cnt_q <= row_cnt_q + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/matmul_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module matmul_top #(
    parameter int ARRAY_N = 4
) (
    input  logic          clk_i,
    input  logic          rst_i,
    input  logic          stall_i,
    input  logic          wgt_valid_i,
    input  tpu_pkg::wgt_t wgt_row_i [ARRAY_N],
    input  logic          wgt_commit_i,
    input  logic          in_valid_i,
    input  tpu_pkg::act_t act_vec_i [ARRAY_N],
    output logic          wgt_loaded_o,
    output logic          busy_o,
    output logic          out_valid_o,
    output tpu_pkg::res_t res_vec_o [ARRAY_N]
);

    logic load_en;
    logic bank_sel;
    logic hold;

    // activations after the input skew, lane c late by c cycles
    tpu_pkg::act_t act_skewed [ARRAY_N];
    // raw row sums, row r late by r cycles
    tpu_pkg::res_t row_res    [ARRAY_N];

    tpu_ctrl #(
        .ARRAY_N (ARRAY_N)
    ) u_tpu_ctrl (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .stall_i      (stall_i),
        .wgt_valid_i  (wgt_valid_i),
        .wgt_commit_i (wgt_commit_i),
        .in_valid_i   (in_valid_i),
        .load_o       (load_en),
        .sel_o        (bank_sel),
        .hold_o       (hold),
        .wgt_loaded_o (wgt_loaded_o),
        .busy_o       (busy_o),
        .out_valid_o  (out_valid_o)
    );

    skew_line #(
        .ARRAY_N (ARRAY_N),
        .data_t  (tpu_pkg::act_t),
        .DESCEND (1'b0)
    ) u_act_skew (
        .clk_i  (clk_i),
        .rst_i  (rst_i),
        .hold_i (hold),
        .lane_i (act_vec_i),
        .lane_o (act_skewed)
    );

    mac_array #(
        .ARRAY_N (ARRAY_N)
    ) u_mac_array (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .hold_i    (hold),
        .load_i    (load_en),
        .sel_i     (bank_sel),
        .wgt_row_i (wgt_row_i),
        .act_i     (act_skewed),
        .row_res_o (row_res)
    );

    // realign rows so the whole vector leaves together
    skew_line #(
        .ARRAY_N (ARRAY_N),
        .data_t  (tpu_pkg::res_t),
        .DESCEND (1'b1)
    ) u_res_deskew (
        .clk_i  (clk_i),
        .rst_i  (rst_i),
        .hold_i (hold),
        .lane_i (row_res),
        .lane_o (res_vec_o)
    );

endmodule

`default_nettype wire

// ==== bench/matmul_assert.sv ====
`timescale 1ns/1ps
`default_nettype none

module matmul_assert (
    input logic clk_i,
    input logic rst_i,
    input logic commit_i,
    input logic loaded_i,
    input logic busy_i,
    input logic out_valid_i
);

    // registers clear on the reset edge
    a_quiet_in_reset: assert property (@(posedge clk_i) rst_i |=> !out_valid_i)
        else $error("out_valid_o high while in reset");

    a_valid_means_busy: assert property (
        @(posedge clk_i) disable iff (rst_i) out_valid_i |-> busy_i)
        else $error("out_valid_o high without busy_o");

    // only a commit empties the shadow bank
    a_loaded_falls_on_commit: assert property (
        @(posedge clk_i) disable iff (rst_i) $fell(loaded_i) |-> $past(commit_i))
        else $error("wgt_loaded_o fell without a commit");

endmodule

bind matmul_top matmul_assert u_matmul_assert (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .commit_i    (wgt_commit_i),
    .loaded_i    (wgt_loaded_o),
    .busy_i      (busy_o),
    .out_valid_i (out_valid_o)
);

`default_nettype wire

// ==== bench/matmul_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module matmul_tb;

    localparam int ARRAY_N = 4;
    localparam int LATENCY = 2 * ARRAY_N - 1;

    typedef tpu_pkg::res_t [ARRAY_N-1:0] res_vec_t;

    logic          clk_i;
    logic          rst_i;
    logic          stall_i;
    logic          wgt_valid_i;
    logic          wgt_commit_i;
    logic          in_valid_i;
    tpu_pkg::wgt_t wgt_row_i [ARRAY_N];
    tpu_pkg::act_t act_vec_i [ARRAY_N];
    logic          wgt_loaded_o;
    logic          busy_o;
    logic          out_valid_o;
    tpu_pkg::res_t res_vec_o [ARRAY_N];

    // model of the two weight banks and of the vectors in flight
    tpu_pkg::wgt_t active_w [ARRAY_N][ARRAY_N];
    tpu_pkg::wgt_t shadow_w [ARRAY_N][ARRAY_N];
    int            rows_in;
    int            ucnt;
    res_vec_t      exp_q [$];
    int            stamp_q [$];
    integer        seed = 32'h69b0;

    matmul_top #(.ARRAY_N(ARRAY_N)) u_matmul_top (.*);

    initial begin
        clk_i = 1'b0;
        forever #50 clk_i = ~clk_i;
    end

    // y = W*a wrapped to RES_W bits
    function automatic res_vec_t ref_matvec(input tpu_pkg::wgt_t w [ARRAY_N][ARRAY_N],
                                            input tpu_pkg::act_t a [ARRAY_N]);
        res_vec_t    y;
        logic [63:0] acc;
        for (int r = 0; r < ARRAY_N; r++) begin
            acc = '0;
            for (int c = 0; c < ARRAY_N; c++) begin
                acc = acc + 64'(w[r][c]) * 64'(a[c]);
            end
            y[r] = acc[tpu_pkg::RES_W-1:0];
        end
        return y;
    endfunction

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Checks failed");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic check_res(input tpu_pkg::res_t got, input tpu_pkg::res_t exp,
                             input string what);
        if (got !== exp) begin
            fail_run($sformatf("[ERROR] %0d ns: %s is %0h, expected %0h",
                               $time, what, got, exp));
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            fail_run($sformatf("[ERROR] %0d ns: %s is %b, expected %b",
                               $time, what, got, exp));
        end
    endtask

    // one cycle of stimulus with stall, weight strobe, commit, vector strobe and all-ones data
    task automatic step(input logic stall, input logic load, input logic commit,
                        input logic send, input logic ones);
        @(posedge clk_i);
        stall_i      <= stall;
        wgt_valid_i  <= load;
        wgt_commit_i <= commit;
        in_valid_i   <= send;
        for (int k = 0; k < ARRAY_N; k++) begin
            wgt_row_i[k] <= tpu_pkg::wgt_t'($random(seed)) | {tpu_pkg::W_W{ones}};
            act_vec_i[k] <= tpu_pkg::act_t'($random(seed)) | {tpu_pkg::ACT_W{ones}};
        end
    endtask

    // hold reset for a number of cycles with all strobes low
    task automatic apply_reset(input int cycles);
        @(posedge clk_i);
        rst_i        <= 1'b1;
        stall_i      <= 1'b0;
        wgt_valid_i  <= 1'b0;
        wgt_commit_i <= 1'b0;
        in_valid_i   <= 1'b0;
        repeat (cycles) @(posedge clk_i);
        rst_i <= 1'b0;
    endtask

    // drop all strobes and wait for the pipeline to drain
    task automatic wait_idle();
        int cycles;
        step(1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
        cycles = 0;
        do begin
            @(negedge clk_i);
            cycles++;
            if (cycles > 100) begin
                fail_run("timeout: busy_o stayed high after the last vector");
            end
        end while (busy_o);
    endtask

    // checker that mirrors the bank rules and compares every delivered vector
    always @(posedge clk_i) begin : scoreboard
        res_vec_t exp_vec;
        logic     busy_now;
        logic     due;
        if (rst_i) begin
            exp_q.delete();
            stamp_q.delete();
            rows_in = 0;
            ucnt    = 0;
            foreach (active_w[r, c]) begin
                active_w[r][c] = '0;
            end
        end else begin
            busy_now = (exp_q.size() != 0);
            due = 1'b0;
            if (busy_now) begin
                due = (stamp_q[0] + LATENCY == ucnt);
            end
            check_flag(busy_o, busy_now, "busy_o");
            check_flag(out_valid_o, due, "out_valid_o");
            check_flag(wgt_loaded_o, rows_in == ARRAY_N, "wgt_loaded_o");
            if (!stall_i) begin
                if (due) begin
                    exp_vec = exp_q.pop_front();
                    void'(stamp_q.pop_front());
                    for (int r = 0; r < ARRAY_N; r++) begin
                        check_res(res_vec_o[r], exp_vec[r], $sformatf("res_vec_o[%0d]", r));
                    end
                end
                if (wgt_commit_i && rows_in == ARRAY_N && !busy_now && !in_valid_i) begin
                    active_w = shadow_w;
                    rows_in  = 0;
                end else if (wgt_valid_i && rows_in < ARRAY_N) begin
                    shadow_w[rows_in] = wgt_row_i;
                    rows_in++;
                end
                if (in_valid_i) begin
                    exp_q.push_back(ref_matvec(active_w, act_vec_i));
                    stamp_q.push_back(ucnt);
                end
                ucnt++;
            end
        end
    end

    initial begin
        rst_i        = 1'b1;
        stall_i      = 1'b0;
        wgt_valid_i  = 1'b0;
        wgt_commit_i = 1'b0;
        in_valid_i   = 1'b0;
        foreach (wgt_row_i[k]) begin
            wgt_row_i[k] = '0;
            act_vec_i[k] = '0;
        end
        repeat (4) @(posedge clk_i);
        rst_i <= 1'b0;

        // full shadow bank and results on the way out when reset hits again
        repeat (ARRAY_N) step(1'b0, 1'b1, 1'b0, 1'b1, 1'b0);
        repeat (LATENCY) step(1'b0, 1'b0, 1'b0, 1'b1, 1'b0);
        apply_reset(4);

        // four rows fill the shadow bank and the fifth must be dropped
        repeat (ARRAY_N + 1) step(1'b0, 1'b1, 1'b0, 1'b0, 1'b0);
        step(1'b0, 1'b0, 1'b1, 1'b0, 1'b0);

        // single vectors
        repeat (3) begin
            step(1'b0, 1'b0, 1'b0, 1'b1, 1'b0);
            wait_idle();
        end

        // back to back
        repeat (24) step(1'b0, 1'b0, 1'b0, 1'b1, 1'b0);
        wait_idle();

        // streaming with random stall pulses
        repeat (40) step(($random(seed) & 3) == 0, 1'b0, 1'b0, 1'b1, 1'b0);
        wait_idle();

        // new matrix loaded under traffic where early commits must be ignored
        repeat (ARRAY_N) step(1'b0, 1'b1, 1'b0, 1'b1, 1'b0);
        step(1'b0, 1'b0, 1'b1, 1'b0, 1'b0);
        step(1'b0, 1'b0, 1'b1, 1'b1, 1'b0);
        repeat (6) step(1'b0, 1'b0, 1'b0, 1'b1, 1'b0);
        wait_idle();
        step(1'b0, 1'b0, 1'b1, 1'b0, 1'b0);
        repeat (8) step(1'b0, 1'b0, 1'b0, 1'b1, 1'b0);
        wait_idle();

        // all ones on both operands
        repeat (ARRAY_N) step(1'b0, 1'b1, 1'b0, 1'b0, 1'b1);
        wait_idle();
        step(1'b0, 1'b0, 1'b1, 1'b0, 1'b0);
        repeat (3) step(1'b0, 1'b0, 1'b0, 1'b1, 1'b1);
        wait_idle();

        repeat (2) @(posedge clk_i);
        $display("All checks passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== sources.f ====
logic/tpu_pkg.sv
logic/mac_cell.sv
logic/skew_line.sv
logic/mac_array.sv
logic/tpu_ctrl.sv
logic/matmul_top.sv
bench/matmul_assert.sv
bench/matmul_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -Wno-fatal
TOP       ?= matmul_tb
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "All checks passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
